// ==== project.f ====
+incdir+include
src/ib_pkg.sv
src/dbg_pkg.sv
src/dbg_inst_gen.sv
src/ib_write_ctl.sv
src/ib_entries.sv
src/ib_top.sv
tests/ib_scoreboard.sv
tests/ib_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator; the exit status follows the simulation
cd "$(dirname "$0")" \
   && verilator --binary --assert -f project.f --top-module ib_tb -o ib_sim \
   && ./obj_dir/ib_sim \
   || exit 1

// ==== tests/ib_tb.sv ====
// random traffic for the instruction buffer; every input changes on the falling edge
// the aligner holds a lane until it is accepted; debug bursts wait for an empty buffer
// comparison against the expected behavior lives in ib_scoreboard

`include "ib_consts.svh"

module ib_tb;
   logic                   clk, rst, flush, take0, take1;
   logic                   in0_valid, in0_ready, in0_pc4, in1_valid, in1_ready, in1_pc4;
   logic [`IB_INSTR_W-1:0] in0_instr, in1_instr, out0_instr, out1_instr;
   logic [`IB_PC_W:1]      in0_pc, in1_pc, out0_pc, out1_pc, next_pc;
   logic                   dbg_cmd_valid, dbg_cmd_write, dbg_cmd_ready;
   logic [1:0]             dbg_cmd_type;
   logic [31:0]            dbg_cmd_addr;
   logic                   out0_valid, out0_pc4, out0_dbg, out0_dbg_wdata_rs1;
   logic                   out0_dbg_fence, out1_valid, out1_pc4;
   logic [`IB_DEPTH-1:0]   ib_valid;
   logic                   sb_failed, sent0, sent1;
   integer                 seed;

   ib_top UUT (.*);
   ib_scoreboard u_sb (.*, .failed(sb_failed));

   always #10 clk = ~clk;

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic int rand_below(input int m);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % m);
   endfunction

   // lane 0 stays put until accepted; a leftover lane 1 moves up
   task automatic drive_lanes();
      if (sent0 && in1_valid && !sent1) begin
         in0_instr = in1_instr;
         in0_pc    = in1_pc;
         in0_pc4   = in1_pc4;
         in1_valid = 1'b0;
      end else if (sent0 || !in0_valid) begin
         in0_valid = rand_below(4) != 0;
         in0_instr = rand_word();
         in0_pc    = next_pc;
         in0_pc4   = rand_below(2) != 0;
         in1_valid = in0_valid & (rand_below(2) != 0);
         in1_instr = rand_word();
         in1_pc    = next_pc + 31'd2;
         in1_pc4   = rand_below(2) != 0;
         next_pc   = next_pc + 31'd4;
      end
   endtask

   task automatic wait_empty();
      int waited;
      waited = 0;
      while (!dbg_cmd_ready) begin
         if (waited == 40) begin
            $display("=== FAIL ===");
            $fatal(1, "buffer never became ready for a debug command");
         end
         take0 = out0_valid;   // drain as fast as possible
         take1 = out1_valid;
         @(negedge clk);
         waited++;
      end
      take0 = 1'b0;
      take1 = 1'b0;
   endtask

   task automatic debug_burst();
      in0_valid = 1'b0;
      in1_valid = 1'b0;
      flush     = 1'b0;
      for (int n = 0; n < 4; n++) begin
         wait_empty();
         dbg_cmd_valid = 1'b1;
         dbg_cmd_write = rand_below(2) != 0;
         dbg_cmd_type  = 2'(rand_below(4));
         dbg_cmd_addr  = (rand_below(2) != 0) ? 32'h7c4 : rand_word();   // fence csr often
         @(negedge clk);
         dbg_cmd_valid = 1'b0;
      end
   endtask

   initial begin
      @(posedge sb_failed);
      $display("=== FAIL ===");
      $fatal(1, "scoreboard check failed");
   end

   initial begin
      seed          = 32'hee6eb4b4;
      clk           = 1'b0;
      rst           = 1'b1;
      flush         = 1'b0;
      take0         = 1'b0;
      take1         = 1'b0;
      in0_valid     = 1'b0;
      in0_instr     = '0;
      in0_pc        = '0;
      in0_pc4       = 1'b0;
      in1_valid     = 1'b0;
      in1_instr     = '0;
      in1_pc        = '0;
      in1_pc4       = 1'b0;
      dbg_cmd_valid = 1'b0;
      dbg_cmd_write = 1'b0;
      dbg_cmd_type  = 2'd0;
      dbg_cmd_addr  = '0;
      next_pc       = 31'h100;
      sent0         = 1'b0;
      sent1         = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int cyc = 0; cyc < 3000; cyc++) begin
         if (cyc % 90 == 45) begin
            debug_burst();
         end else begin
            drive_lanes();
            take0 = out0_valid & (rand_below(4) != 0);
            take1 = take0 & out1_valid & (rand_below(2) != 0);
            flush = rand_below(32) == 0;
         end
         #5;   // readies have settled by mid-cycle
         sent0 = in0_valid & in0_ready;
         sent1 = sent0 & in1_valid & in1_ready;
         @(negedge clk);
      end
      if (sb_failed === 1'b1) begin
         $display("=== FAIL ===");
         $fatal(1, "a check failed during the run");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

// ==== tests/ib_scoreboard.sv ====
// queue model of the instruction buffer, compared with the DUT at every rising edge
// the model pops the takes first and then appends the writes behind the survivors
// assumes the driver takes only valid entries and raises take1 only with take0

`include "ib_consts.svh"

module ib_scoreboard (
   input  logic                   clk, rst, flush, take0, take1,
   input  logic                   in0_valid, in0_ready, in0_pc4,
   input  logic                   in1_valid, in1_ready, in1_pc4,
   input  logic [`IB_INSTR_W-1:0] in0_instr, in1_instr, out0_instr, out1_instr,
   input  logic [`IB_PC_W:1]      in0_pc, in1_pc, out0_pc, out1_pc,
   input  logic                   dbg_cmd_valid, dbg_cmd_write, dbg_cmd_ready,
   input  logic [1:0]             dbg_cmd_type,
   input  logic [31:0]            dbg_cmd_addr,
   input  logic                   out0_valid, out0_pc4, out0_dbg, out0_dbg_wdata_rs1,
   input  logic                   out0_dbg_fence, out1_valid, out1_pc4,
   input  logic [`IB_DEPTH-1:0]   ib_valid,
   output logic                   failed
);
   import ib_pkg::*;

   ib_entry_t model_q[$];   // head is entry 0
   logic      flush_seen;   // flush as registered inside the buffer
   logic      first_edge;   // first edge after reset release
   int        cnt;

   function automatic ib_entry_t dbg_expect(input logic wr, input logic [1:0] ctype,
                                            input logic [31:0] addr);
      ib_entry_t e;
      e               = '0;
      e.pc4           = 1'b1;
      e.dbg           = 1'b1;
      e.dbg_wdata_rs1 = wr;
      if (ctype == 2'd1) begin
         // csrrw / csrrs x0, csr, x0
         e.instr     = {addr[11:0], 5'd0, (wr ? 3'b001 : 3'b010), 5'd0, 7'h73};
         e.dbg_fence = wr && (addr[11:0] == 12'h7c4);
      end else if (wr) begin
         e.instr = {7'd0, 5'd0, 5'd0, 3'b110, addr[4:0], 7'h33};   // or reg, x0, x0
      end else begin
         e.instr = {7'd0, 5'd0, addr[4:0], 3'b110, 5'd0, 7'h33};   // or x0, reg, x0
      end
      return e;
   endfunction

   function automatic ib_entry_t lane_entry(input logic [`IB_INSTR_W-1:0] instr,
                                            input logic [`IB_PC_W:1] pc, input logic pc4);
      return '{instr: instr, pc: pc, pc4: pc4, dbg: 1'b0, dbg_wdata_rs1: 1'b0, dbg_fence: 1'b0};
   endfunction

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (!failed) begin
         assert (got == exp) else begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            failed = 1'b1;
         end
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         model_q.delete();
         flush_seen = 1'b0;
         first_edge = 1'b1;
         failed     = 1'b0;
      end else begin
         cnt = model_q.size();
         if (first_edge) begin
            check_value("out0_dbg", 64'(out0_dbg), 64'(0));   // reset value
            first_edge = 1'b0;
         end
         check_value("ib_valid", 64'(ib_valid), 64'((1 << cnt) - 1));   // contiguous from 0
         check_value("out0_valid", 64'(out0_valid), 64'(cnt > 0));
         check_value("out1_valid", 64'(out1_valid), 64'(cnt > 1));
         check_value("in0_ready", 64'(in0_ready), 64'(cnt < 4 && !flush_seen && !dbg_cmd_valid));
         check_value("in1_ready", 64'(in1_ready), 64'(cnt < 3 && !flush_seen));
         check_value("dbg_cmd_ready", 64'(dbg_cmd_ready), 64'(cnt == 0 && !flush_seen));
         if (cnt > 0) begin
            check_value("out0_instr", 64'(out0_instr), 64'(model_q[0].instr));
            check_value("out0_pc", 64'(out0_pc), 64'(model_q[0].pc));
            check_value("out0_pc4", 64'(out0_pc4), 64'(model_q[0].pc4));
            check_value("out0_dbg", 64'(out0_dbg), 64'(model_q[0].dbg));
            check_value("out0_dbg_wdata_rs1", 64'(out0_dbg_wdata_rs1),
                        64'(model_q[0].dbg_wdata_rs1));
            check_value("out0_dbg_fence", 64'(out0_dbg_fence), 64'(model_q[0].dbg_fence));
         end
         if (cnt > 1) begin
            check_value("out1_instr", 64'(out1_instr), 64'(model_q[1].instr));
            check_value("out1_pc", 64'(out1_pc), 64'(model_q[1].pc));
            check_value("out1_pc4", 64'(out1_pc4), 64'(model_q[1].pc4));
         end

         if (flush_seen) begin
            model_q.delete();   // writes and takes of this cycle are lost
         end else begin
            if (take0) begin
               void'(model_q.pop_front());
            end
            if (take0 && take1) begin
               void'(model_q.pop_front());
            end
            if (dbg_cmd_valid) begin
               // mem and reserved are acknowledged but dropped
               if (cnt == 0 && dbg_cmd_type < 2'd2) begin
                  model_q.push_back(dbg_expect(dbg_cmd_write, dbg_cmd_type, dbg_cmd_addr));
               end
            end else if (in0_valid && cnt < 4) begin
               model_q.push_back(lane_entry(in0_instr, in0_pc, in0_pc4));
               if (in1_valid && cnt < 3) begin
                  model_q.push_back(lane_entry(in1_instr, in1_pc, in1_pc4));
               end
            end
         end
         flush_seen = flush;
      end
   end

endmodule

// ==== src/ib_top.sv ====
// instruction buffer between a dual-lane aligner and a dual-issue decoder
// single thread, single clock; flush is registered and empties the buffer in two edges
// debug gpr/csr commands enter at the head, only into an empty buffer

`include "ib_consts.svh"

module ib_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   flush,
   input  logic                   in0_valid,
   input  logic [`IB_INSTR_W-1:0] in0_instr,
   input  logic [`IB_PC_W:1]      in0_pc,
   input  logic                   in0_pc4,
   output logic                   in0_ready,
   input  logic                   in1_valid,
   input  logic [`IB_INSTR_W-1:0] in1_instr,
   input  logic [`IB_PC_W:1]      in1_pc,
   input  logic                   in1_pc4,
   output logic                   in1_ready,
   input  logic                   dbg_cmd_valid,
   input  logic                   dbg_cmd_write,
   input  logic [1:0]             dbg_cmd_type,
   input  logic [31:0]            dbg_cmd_addr,
   output logic                   dbg_cmd_ready,
   input  logic                   take0,
   input  logic                   take1,
   output logic                   out0_valid,
   output logic [`IB_INSTR_W-1:0] out0_instr,
   output logic [`IB_PC_W:1]      out0_pc,
   output logic                   out0_pc4,
   output logic                   out0_dbg,
   output logic                   out0_dbg_wdata_rs1,
   output logic                   out0_dbg_fence,
   output logic                   out1_valid,
   output logic [`IB_INSTR_W-1:0] out1_instr,
   output logic [`IB_PC_W:1]      out1_pc,
   output logic                   out1_pc4,
   output logic [`IB_DEPTH-1:0]   ib_valid
);
   import ib_pkg::*;
   import dbg_pkg::*;

   ib_entry_t            new0, new1, dbg_entry, entry0, entry1;
   dbg_cmd_type_e        dbg_type;
   logic                 dbg_accept_entry;
   logic                 load_dbg;
   logic [1:0]           load0_sel, load1_sel, shift_sel;
   logic [`IB_DEPTH-1:0] entry_en;

   assign dbg_type = dbg_cmd_type_e'(dbg_cmd_type);

   // aligner lanes never carry debug info
   assign new0 = '{instr: in0_instr, pc: in0_pc, pc4: in0_pc4,
                   dbg: 1'b0, dbg_wdata_rs1: 1'b0, dbg_fence: 1'b0};
   assign new1 = '{instr: in1_instr, pc: in1_pc, pc4: in1_pc4,
                   dbg: 1'b0, dbg_wdata_rs1: 1'b0, dbg_fence: 1'b0};

   dbg_inst_gen u_dbg_inst_gen (
      .dbg_cmd_write    (dbg_cmd_write),
      .dbg_cmd_type     (dbg_type),
      .dbg_cmd_addr     (dbg_cmd_addr),
      .dbg_entry        (dbg_entry),
      .dbg_accept_entry (dbg_accept_entry)
   );

   ib_write_ctl u_write_ctl (
      .clk              (clk),
      .rst              (rst),
      .flush            (flush),
      .in0_valid        (in0_valid),
      .in1_valid        (in1_valid),
      .dbg_cmd_valid    (dbg_cmd_valid),
      .dbg_accept_entry (dbg_accept_entry),
      .take0            (take0),
      .take1            (take1),
      .ib_valid         (ib_valid),
      .in0_ready        (in0_ready),
      .in1_ready        (in1_ready),
      .dbg_cmd_ready    (dbg_cmd_ready),
      .load0_sel        (load0_sel),
      .load1_sel        (load1_sel),
      .load_dbg         (load_dbg),
      .shift_sel        (shift_sel),
      .entry_en         (entry_en)
   );

   ib_entries u_entries (
      .clk       (clk),
      .rst       (rst),
      .new0      (new0),
      .new1      (new1),
      .dbg_entry (dbg_entry),
      .load0_sel (load0_sel),
      .load1_sel (load1_sel),
      .load_dbg  (load_dbg),
      .shift_sel (shift_sel),
      .entry_en  (entry_en),
      .entry0    (entry0),
      .entry1    (entry1)
   );

   assign out0_valid         = ib_valid[0];
   assign out0_instr         = entry0.instr;
   assign out0_pc            = entry0.pc;
   assign out0_pc4           = entry0.pc4;
   assign out0_dbg           = entry0.dbg;
   assign out0_dbg_wdata_rs1 = entry0.dbg_wdata_rs1;
   assign out0_dbg_fence     = entry0.dbg_fence;

   assign out1_valid = ib_valid[1];
   assign out1_instr = entry1.instr;
   assign out1_pc    = entry1.pc;
   assign out1_pc4   = entry1.pc4;

endmodule

// ==== src/ib_entries.sv ====
// the four buffer registers and their input muxes
// selects come from ib_write_ctl; lane targets always sit above any shifted entry
// after reset only the dbg flags are defined; the payload starts unknown

`include "ib_consts.svh"

module ib_entries (
   input  logic                 clk,
   input  logic                 rst,
   input  ib_pkg::ib_entry_t    new0,
   input  ib_pkg::ib_entry_t    new1,
   input  ib_pkg::ib_entry_t    dbg_entry,
   input  logic [1:0]           load0_sel,
   input  logic [1:0]           load1_sel,
   input  logic                 load_dbg,
   input  logic [1:0]           shift_sel,
   input  logic [`IB_DEPTH-1:0] entry_en,
   output ib_pkg::ib_entry_t    entry0,
   output ib_pkg::ib_entry_t    entry1
);
   import ib_pkg::*;

   ib_entry_t ent_q   [`IB_DEPTH];
   ib_entry_t ent_nxt [`IB_DEPTH];
   ib_entry_t ent_ext [`IB_DEPTH+2];   // padded so entry 3 can look two up

   always_comb begin
      for (int i = 0; i < `IB_DEPTH; i++) begin
         ent_ext[i] = ent_q[i];
      end
      ent_ext[`IB_DEPTH]   = '0;
      ent_ext[`IB_DEPTH+1] = '0;
   end

   always_comb begin
      for (int i = 0; i < `IB_DEPTH; i++) begin
         if (load_dbg && (i == 0)) begin
            ent_nxt[i] = dbg_entry;            // buffer is empty here
         end else if (load0_sel == 2'(i)) begin
            ent_nxt[i] = new0;
         end else if (load1_sel == 2'(i)) begin
            ent_nxt[i] = new1;
         end else if (shift_sel[1]) begin
            ent_nxt[i] = ent_ext[i+2];         // two taken
         end else if (shift_sel[0]) begin
            ent_nxt[i] = ent_ext[i+1];
         end else begin
            ent_nxt[i] = ent_q[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `IB_DEPTH; i++) begin
         if (rst) begin
            ent_q[i].dbg <= 1'b0;
         end else if (entry_en[i]) begin
            ent_q[i] <= ent_nxt[i];
         end
      end
   end

   // decoder sees the head two only
   assign entry0 = ent_q[0];
   assign entry1 = ent_q[1];

endmodule

// ==== src/ib_write_ctl.sv ====
// valid vector, readiness and write/shift selects for the four-entry buffer
// readiness ignores this cycle's takes and has no path from the decoder
// assumes take1 only with take0, and takes only on valid entries
// a debug command is only accepted into an empty buffer

`include "ib_consts.svh"

module ib_write_ctl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 flush,
   input  logic                 in0_valid,
   input  logic                 in1_valid,
   input  logic                 dbg_cmd_valid,
   input  logic                 dbg_accept_entry,
   input  logic                 take0,
   input  logic                 take1,
   output logic [`IB_DEPTH-1:0] ib_valid,
   output logic                 in0_ready,
   output logic                 in1_ready,
   output logic                 dbg_cmd_ready,
   output logic [1:0]           load0_sel,
   output logic [1:0]           load1_sel,
   output logic                 load_dbg,
   output logic [1:0]           shift_sel,
   output logic [`IB_DEPTH-1:0] entry_en
);

   logic                 flush_q;
   logic [`IB_DEPTH-1:0] ibval;
   logic [`IB_DEPTH-1:0] ibval_nxt;
   logic [`IB_DEPTH-1:0] shift_ibval;
   logic [`IB_DEPTH-1:0] wr_vec;
   logic                 shift1, shift2;
   logic                 i0_wr, i1_wr, dbg_wr;
   logic [1:0]           free_slot;

   always_ff @(posedge clk) begin
      if (rst) begin
         flush_q <= 1'b0;
         ibval   <= '0;
      end else begin
         flush_q <= flush;
         ibval   <= ibval_nxt;
      end
   end

   // room is judged before this cycle's takes
   assign in0_ready     = ~ibval[3] & ~flush_q & ~dbg_cmd_valid;
   assign in1_ready     = ~ibval[2] & ~flush_q;
   assign dbg_cmd_ready = ~(|ibval) & ~flush_q;

   assign i0_wr  = in0_valid & in0_ready;
   assign i1_wr  = in1_valid & in1_ready & i0_wr;   // lane 1 never alone
   assign dbg_wr = dbg_cmd_valid & dbg_cmd_ready & dbg_accept_entry;

   assign shift1    = take0 & ~take1;
   assign shift2    = take0 & take1;
   assign shift_sel = {shift2, shift1};

   always_comb begin
      case (shift_sel)
         2'b01:   shift_ibval = {1'b0, ibval[3:1]};
         2'b10:   shift_ibval = {2'b0, ibval[3:2]};
         default: shift_ibval = ibval;
      endcase
   end

   // first free slot once the takes have shifted the queue
   always_comb begin
      if (shift_ibval[2]) begin
         free_slot = 2'd3;
      end else if (shift_ibval[1]) begin
         free_slot = 2'd2;
      end else if (shift_ibval[0]) begin
         free_slot = 2'd1;
      end else begin
         free_slot = 2'd0;
      end
   end

   assign load_dbg  = dbg_wr;
   assign load0_sel = dbg_wr ? 2'd0 : free_slot;
   assign load1_sel = (load0_sel == 2'd3) ? 2'd3 : load0_sel + 2'd1;   // saturates only when i1 is blocked

   always_comb begin
      for (int i = 0; i < `IB_DEPTH; i++) begin
         wr_vec[i] = (i0_wr & (load0_sel == 2'(i))) | (i1_wr & (load1_sel == 2'(i)));
      end
      wr_vec[0] = wr_vec[0] | dbg_wr;
   end

   assign entry_en  = wr_vec | (shift_ibval & {`IB_DEPTH{take0}});
   assign ibval_nxt = (shift_ibval | wr_vec) & ~{`IB_DEPTH{flush_q}};
   assign ib_valid  = ibval;

endmodule

// ==== src/dbg_inst_gen.sv ====
// turns a debug gpr/csr command into an equivalent riscv instruction
// purely combinational; the result is only written when dbg_accept_entry is high
// write data is not carried; dbg_wdata_rs1 tells the decoder to take it via rs1

`include "ib_consts.svh"

module dbg_inst_gen (
   input  logic                   dbg_cmd_write,
   input  dbg_pkg::dbg_cmd_type_e dbg_cmd_type,
   input  logic [31:0]            dbg_cmd_addr,
   output ib_pkg::ib_entry_t      dbg_entry,
   output logic                   dbg_accept_entry
);
   import ib_pkg::*;
   import dbg_pkg::*;

   logic [4:0]  dreg;
   logic [11:0] dcsr;
   logic [2:0]  csr_f3;
   logic        is_csr;
   rv_opcode_e  opc;

   assign dreg   = dbg_cmd_addr[4:0];
   assign dcsr   = dbg_cmd_addr[11:0];
   assign is_csr = (dbg_cmd_type == dbg_csr);
   assign opc    = is_csr ? opc_system : opc_op;
   assign csr_f3 = dbg_cmd_write ? `RV_F3_CSRRW : `RV_F3_CSRRS;

   // mem and reserved never reach the buffer
   assign dbg_accept_entry = (dbg_cmd_type == dbg_gpr) | is_csr;

   always_comb begin
      dbg_entry.pc            = '0;
      dbg_entry.pc4           = 1'b1;
      dbg_entry.dbg           = 1'b1;
      dbg_entry.dbg_wdata_rs1 = dbg_cmd_write;
      dbg_entry.dbg_fence     = is_csr & dbg_cmd_write & (dcsr == `DBG_FENCE_CSR);

      if (is_csr) begin
         // csrrw/csrrs x0, csr, x0
         dbg_entry.instr = {dcsr, 5'd0, csr_f3, 5'd0, opc};
      end else if (dbg_cmd_write) begin
         dbg_entry.instr = {12'd0, 5'd0, `RV_F3_OR, dreg, opc};   // or reg, x0, x0
      end else begin
         dbg_entry.instr = {12'd0, dreg, `RV_F3_OR, 5'd0, opc};   // or x0, reg, x0
      end
   end

endmodule

// ==== src/dbg_pkg.sv ====
// debug command types and the instruction opcodes that the debug encoder emits
// only gpr and csr commands produce a buffer entry
// mem and reserved are acknowledged and dropped by the buffer

`include "ib_consts.svh"

package dbg_pkg;

   // abstract command type, as carried on dbg_cmd_type
   typedef enum logic [1:0] {
      dbg_gpr  = 2'd0,
      dbg_csr  = 2'd1,
      dbg_mem  = 2'd2,   // handled outside the buffer
      dbg_rsvd = 2'd3
   } dbg_cmd_type_e;

   // major opcodes of the generated instructions
   typedef enum logic [6:0] {
      opc_op     = `RV_OPC_OP,      // or
      opc_system = `RV_OPC_SYSTEM   // csrrw, csrrs
   } rv_opcode_e;

endpackage

// ==== src/ib_pkg.sv ====
// buffer slot type, shared by the RTL and the testbench
// pc is stored as bits 31:1; bit 0 is always zero for aligned fetch
// the three dbg fields are only meaningful for an entry built from a debug command

`include "ib_consts.svh"

package ib_pkg;

   // one buffer slot
   typedef struct packed {
      logic [`IB_INSTR_W-1:0] instr;
      logic [`IB_PC_W:1]      pc;
      logic                   pc4;            // 4B instruction, else 2B
      logic                   dbg;            // came from a debug command
      logic                   dbg_wdata_rs1;  // debug write data goes onto rs1
      logic                   dbg_fence;      // write to the debug fence csr
   } ib_entry_t;

endpackage

// ==== include/ib_consts.svh ====
// constants for the four-entry instruction buffer and the debug instruction encoder
// depth and lane count are fixed; changing IB_DEPTH needs new write-position logic
// pc carries bits 31:1 only, so IB_PC_W is one less than the address width
`ifndef IB_CONSTS_SVH
`define IB_CONSTS_SVH

`define IB_DEPTH        4
`define IB_INSTR_W      32
`define IB_PC_W         31

// riscv major opcodes used by debug commands
`define RV_OPC_OP       7'b0110011
`define RV_OPC_SYSTEM   7'b1110011

`define RV_F3_OR        3'b110
`define RV_F3_CSRRW     3'b001
`define RV_F3_CSRRS     3'b010

`define DBG_FENCE_CSR   12'h7c4   // debug mode only

`endif
